/* branch_predictor.f */
+incdir+hw
hw/bp_pkg.sv
hw/obq.sv
hw/pattern_table.sv
hw/resolve_unit.sv
hw/branch_predictor.sv
tb/bp_checker.sv
tb/branch_predictor_tb.sv

/* hw/bp_defines.svh */
// sizing macros for the branch direction predictor: queue depth, history width, table depth
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// number of outstanding branches the ordered queue can track
`define OBQ_SIZE 8

// global history width
// bit BH_SIZE-1 holds the newest outcome
`define BH_SIZE 8

// counter table index width
// must match BH_SIZE so pc and history can be xor-ed bit for bit
`define PHT_BITS 8

// number of two-bit counters in the table
`define PHT_SIZE (1 << `PHT_BITS)

`endif

/* hw/bp_pkg.sv */
// shared types: queue index, branch history, table index, queue row, saturating counter
package bp_pkg;

	`include "bp_defines.svh"

	// queue index or occupancy count
	// one extra bit so a full queue count of OBQ_SIZE fits
	typedef logic [$clog2(`OBQ_SIZE + 1)-1:0] obq_idx_t;

	// global branch history
	// newest outcome in the msb, older outcomes toward bit 0
	typedef logic [`BH_SIZE-1:0] history_t;

	// index into the counter table
	typedef logic [`PHT_BITS-1:0] pht_idx_t;

	// one outstanding branch
	// branch_history already contains this branch's predicted bit
	// pht_index is the counter that produced the prediction, used again for training
	typedef struct packed {
		history_t branch_history;
		pht_idx_t pht_index;
	} obq_row_t;

	// two-bit saturating counter
	// 00 strong not-taken, 01 weak not-taken, 10 weak taken, 11 strong taken
	typedef logic [1:0] counter_t;

endpackage

/* hw/branch_predictor.sv */
// top level of the direction predictor: queue, counter table and resolve unit
`include "bp_defines.svh"

module branch_predictor import bp_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        predict_valid,
	input  logic [31:0] predict_pc,
	input  logic        resolve_valid,
	input  obq_idx_t    resolve_tag,
	input  logic        resolve_taken,
	input  logic        retire_valid,
	input  obq_idx_t    retire_count,
	output logic        pred_taken,
	output obq_idx_t    pred_tag,
	output logic        mispredict,
	output obq_idx_t    obq_count,
	output logic        obq_full
);

	history_t spec_history;
	pht_idx_t predict_index;
	obq_row_t resolve_row;
	logic     clear_en;

	// training path from the resolve unit into the table
	logic     update_en;
	pht_idx_t update_index;
	logic     update_taken;

	// gshare style index, word-aligned pc bits mixed with the speculative history
	assign predict_index = predict_pc[`PHT_BITS+1:2] ^ pht_idx_t'(spec_history);

	obq i_obq (
		.clock          (clock),
		.reset          (reset),
		.write_en       (predict_valid),
		.write_pc_index (predict_index),
		.write_taken    (pred_taken),
		.clear_en       (clear_en),
		.clear_index    (resolve_tag),
		.shift_en       (retire_valid),
		.shift_count    (retire_count),
		.read_index     (resolve_tag),
		.read_row       (resolve_row),
		.spec_history   (spec_history),
		.row_tag        (pred_tag),
		.count          (obq_count),
		.full           (obq_full)
	);

	pattern_table i_pattern_table (
		.clock        (clock),
		.reset        (reset),
		.read_index   (predict_index),
		.read_taken   (pred_taken),
		.update_en    (update_en),
		.update_index (update_index),
		.update_taken (update_taken)
	);

	resolve_unit i_resolve_unit (
		.clock         (clock),
		.reset         (reset),
		.resolve_valid (resolve_valid),
		.resolve_tag   (resolve_tag),
		.resolve_taken (resolve_taken),
		.row           (resolve_row),
		.count         (obq_count),
		.mispredict    (mispredict),
		.clear_en      (clear_en),
		.update_en     (update_en),
		.update_index  (update_index),
		.update_taken  (update_taken)
	);

endmodule

/* hw/obq.sv */
// ordered queue of outstanding branches with retire, mispredict truncation and append
`include "bp_defines.svh"

module obq import bp_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     write_en,
	input  pht_idx_t write_pc_index,
	input  logic     write_taken,
	input  logic     clear_en,
	input  obq_idx_t clear_index,
	input  logic     shift_en,
	input  obq_idx_t shift_count,
	input  obq_idx_t read_index,
	output obq_row_t read_row,
	output history_t spec_history,
	output obq_idx_t row_tag,
	output obq_idx_t count,
	output logic     full
);

	// row address width is one bit narrower than obq_idx_t
	localparam int ROW_W = $clog2(`OBQ_SIZE);

	// oldest branch sits at row 0 and tail counts the valid rows
	obq_row_t rows [`OBQ_SIZE];
	obq_row_t rows_next [`OBQ_SIZE];
	obq_idx_t tail;
	obq_idx_t tail_next;

	// history of the last retired branch
	history_t committed_history;
	history_t committed_next;

	// per-cycle decisions
	logic     do_retire;
	logic     do_append;
	obq_idx_t clear_pos;
	obq_idx_t append_pos;
	obq_row_t new_row;

	assign count = tail;
	assign full  = (tail == obq_idx_t'(`OBQ_SIZE));

	// newest row gives the speculative history
	// committed history stands in when nothing is in flight
	assign spec_history = (tail == '0) ? committed_history :
		rows[ROW_W'(tail - 1'b1)].branch_history;

	// resolve side row read
	// the resolve unit rejects tags at or above count
	assign read_row = rows[read_index[ROW_W-1:0]];

	// shift in the predicted bit at the newest end of the history
	assign new_row.branch_history = {write_taken, spec_history[`BH_SIZE-1:1]};
	assign new_row.pht_index      = write_pc_index;

	// the new row lands wherever the tail sits after retire and truncate
	assign row_tag = append_pos;

	// full is judged on the queue as it stands before the edge
	assign do_append = write_en && !full;

	always_comb begin
		rows_next      = rows;
		tail_next      = tail;
		committed_next = committed_history;

		// first retire from the head
		// skipped when the count is zero or too large, or when it would take the mispredicted row
		do_retire = shift_en && (shift_count != '0) && (shift_count <= tail) &&
			!(clear_en && (clear_index < shift_count));

		if (do_retire) begin
			for (int i = 0; i < `OBQ_SIZE; i++) begin
				if (i + int'(shift_count) < `OBQ_SIZE) begin
					rows_next[i] = rows[i + int'(shift_count)];
				end
			end
			tail_next      = tail - shift_count;
			committed_next = rows[ROW_W'(shift_count - 1'b1)].branch_history;
		end

		// then truncate after the resolved row at its shifted position
		clear_pos = do_retire ? (clear_index - shift_count) : clear_index;

		if (clear_en) begin
			tail_next = clear_pos + 1'b1;
			// the recorded guess was wrong, so flip the newest bit of that row
			rows_next[ROW_W'(clear_pos)].branch_history[`BH_SIZE-1] =
				~rows_next[ROW_W'(clear_pos)].branch_history[`BH_SIZE-1];
		end

		// last append the new prediction at the adjusted tail
		append_pos = tail_next;

		if (do_append) begin
			rows_next[ROW_W'(append_pos)] = new_row;
			tail_next = append_pos + 1'b1;
		end
	end

	// only rows below tail hold live branches
	always_ff @(posedge clock) begin
		rows <= rows_next;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tail              <= '0;
			committed_history <= '0;
		end else begin
			tail              <= tail_next;
			committed_history <= committed_next;
		end
	end

endmodule

/* hw/pattern_table.sv */
// table of two-bit saturating counters with a prediction read port and a training write port
`include "bp_defines.svh"

module pattern_table import bp_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  pht_idx_t read_index,
	output logic     read_taken,
	input  logic     update_en,
	input  pht_idx_t update_index,
	input  logic     update_taken
);

	// every counter starts weakly not-taken
	localparam counter_t WEAK_NOT_TAKEN = 2'b01;

	counter_t counters [`PHT_SIZE];

	// currently stored value of the counter being trained
	counter_t update_old;

	// prediction is the counter msb, no bypass from a same-cycle update
	assign read_taken = counters[read_index][1];

	assign update_old = counters[update_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PHT_SIZE; i++) begin
				counters[i] <= WEAK_NOT_TAKEN;
			end
		end else if (update_en) begin
			// count up on taken, down on not taken
			if (update_taken) begin
				// saturate at strong taken
				if (update_old != 2'b11) begin
					counters[update_index] <= update_old + 2'd1;
				end
			end else begin
				// saturate at strong not-taken
				if (update_old != 2'b00) begin
					counters[update_index] <= update_old - 2'd1;
				end
			end
		end
	end

endmodule

/* hw/resolve_unit.sv */
// branch resolve check: tag validation, mispredict detection, registered counter training
`include "bp_defines.svh"

module resolve_unit import bp_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     resolve_valid,
	input  obq_idx_t resolve_tag,
	input  logic     resolve_taken,
	input  obq_row_t row,
	input  obq_idx_t count,
	output logic     mispredict,
	output logic     clear_en,
	output logic     update_en,
	output pht_idx_t update_index,
	output logic     update_taken
);

	// resolve refers to a live row of the queue before the edge
	logic tag_ok;
	logic resolve_hit;
	// the direction this branch was predicted with
	logic recorded_taken;

	assign tag_ok         = (resolve_tag < count);
	assign resolve_hit    = resolve_valid && tag_ok;
	assign recorded_taken = row.branch_history[`BH_SIZE-1];

	// combinational, same cycle as the resolve strobe
	assign mispredict = resolve_hit && (resolve_taken != recorded_taken);

	// truncation index is the tag itself
	// the queue applies any same-cycle retire shift on its side
	assign clear_en = mispredict;

	// training strobe, one cycle behind the resolve
	always_ff @(posedge clock) begin
		if (reset) begin
			update_en <= 1'b0;
		end else begin
			update_en <= resolve_hit;
		end
	end

	// write payload, only looked at while update_en is high
	always_ff @(posedge clock) begin
		update_index <= row.pht_index;
		update_taken <= resolve_taken;
	end

endmodule

/* tb/bp_checker.sv */
// checker: samples DUT outputs late in each cycle, compares with trace columns, counts per test
module bp_checker import bp_pkg::*; (
	input  logic       clock,
	input  logic       line_valid,
	input  logic       trace_done,
	input  logic [7:0] test_num,
	input  logic       predict_valid,
	input  logic       pred_taken,
	input  obq_idx_t   pred_tag,
	input  logic       mispredict,
	input  obq_idx_t   obq_count,
	input  logic       obq_full,
	input  logic       exp_taken,
	input  obq_idx_t   exp_tag,
	input  logic       exp_mispredict,
	input  obq_idx_t   exp_count,
	input  logic       exp_full,
	output logic       report_done,
	output int         tests_passed,
	output int         tests_failed,
	output int         check_count,
	output int         error_count
);

	// one unit before the next rising edge
	localparam int SAMPLE_DELAY = 7;

	logic [7:0] current_test;
	bit         test_open;
	int         test_checks;
	int         test_errors;

	initial begin
		report_done  = 1'b0;
		tests_passed = 0;
		tests_failed = 0;
		check_count  = 0;
		error_count  = 0;
		test_open    = 1'b0;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		test_checks++;
		if (actual !== expected) begin
			error_count++;
			test_errors++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// summary line for the test that just ended
	task automatic close_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %0d passed, %0d checks", current_test, test_checks);
		end else begin
			tests_failed++;
			$display("test %0d failed, %0d of %0d checks wrong", current_test, test_errors,
				test_checks);
		end
		test_open = 1'b0;
	endtask

	always @(posedge clock) begin
		#SAMPLE_DELAY;
		if (line_valid) begin
			// a new test number closes the previous test
			if (test_open && test_num != current_test) begin
				close_test();
			end
			if (!test_open) begin
				current_test = test_num;
				test_checks  = 0;
				test_errors  = 0;
				test_open    = 1'b1;
			end
			// tag only means something when the row is really recorded
			if (predict_valid) begin
				compare_value("pred_taken", exp_taken, pred_taken);
			end
			if (predict_valid && !exp_full) begin
				compare_value("pred_tag", exp_tag, pred_tag);
			end
			compare_value("mispredict", exp_mispredict, mispredict);
			compare_value("obq_count", exp_count, obq_count);
			compare_value("obq_full", exp_full, obq_full);
		end else if (trace_done && !report_done) begin
			if (test_open) begin
				close_test();
			end
			report_done = 1'b1;
		end
	end

endmodule

/* tb/bp_trace.txt */
// test predict_valid predict_pc resolve_valid resolve_tag resolve_taken retire_valid retire_count
// then expected pred_taken pred_tag mispredict obq_count obq_full, hex, test ff ends the trace
1 1 00001040 0 0 0 0 0 0 0 0 0 0 // first prediction, weak not-taken, tag 0
1 1 000010cc 0 0 0 0 0 0 1 0 1 0
1 0 00000000 0 0 0 1 2 0 0 0 2 0 // retire both
2 1 00001004 0 0 0 0 0 0 0 0 0 0
2 1 00001008 0 0 0 0 0 0 1 0 1 0
2 1 0000100c 0 0 0 0 0 0 2 0 2 0
2 1 00001010 0 0 0 0 0 0 3 0 3 0
2 1 00001014 0 0 0 0 0 0 4 0 4 0
2 1 00001018 0 0 0 0 0 0 5 0 5 0
2 1 0000101c 0 0 0 0 0 0 6 0 6 0
2 1 00001020 0 0 0 0 0 0 7 0 7 0
2 1 00001024 0 0 0 0 0 0 0 0 8 1 // ninth prediction dropped
2 0 00000000 0 0 0 0 0 0 0 0 8 1
3 0 00000000 1 0 0 0 0 0 0 0 8 1 // correct resolve
3 0 00000000 1 3 0 0 0 0 0 0 8 1
3 0 00000000 0 0 0 1 8 0 0 0 8 1 // retire all eight
3 1 00001080 0 0 0 0 0 0 0 0 0 0 // counter 20 used
3 0 00000000 1 0 1 0 0 0 0 1 1 0 // taken, mispredict flips the row
3 0 00000000 1 0 1 0 0 0 0 0 1 0 // taken again, now correct
3 0 00000000 0 0 0 1 1 0 0 0 1 0 // committed history 80
3 1 00001280 0 0 0 0 0 1 0 0 0 0 // a0 xor 80 hits counter 20, now taken
3 0 00000000 0 0 0 1 1 0 0 0 1 0
4 1 00001140 0 0 0 0 0 0 0 0 0 0
4 1 00001144 0 0 0 0 0 0 1 0 1 0
4 1 00001148 0 0 0 0 0 0 2 0 2 0
4 1 0000114c 0 0 0 0 0 0 3 0 3 0
4 1 00001150 0 0 0 0 0 0 4 0 4 0
4 1 00001154 0 0 0 0 0 0 5 0 5 0
4 0 00000000 1 2 1 0 0 0 0 1 6 0 // mispredict at tag 2 of 6
4 1 000012e0 0 0 0 0 0 1 3 0 3 0 // history 98 gives counter 20, 18 would not
5 1 00001040 1 3 0 1 2 0 2 1 4 0 // retire, truncate, append together
5 1 00001044 0 0 0 0 0 0 3 0 3 0
5 0 00000000 0 0 0 1 5 0 0 0 4 0 // retire beyond count ignored
5 0 00000000 1 0 0 1 1 0 0 1 4 0 // retire would take resolved row, ignored
6 1 00001180 0 0 0 0 0 0 1 0 1 0
6 0 00000000 0 0 0 1 2 0 0 0 2 0 // committed history 0c
6 1 000010b0 0 0 0 0 0 1 0 0 0 0 // 2c xor 0c hits counter 20
6 0 00000000 1 1 1 0 0 0 0 0 1 0 // tag at count ignored
6 0 00000000 0 0 0 0 0 0 0 0 1 0
ff 0 00000000 0 0 0 0 0 0 0 0 0 0

/* tb/branch_predictor_tb.sv */
// testbench top: clock and reset, trace reader, stimulus driver, DUT and checker instances
module branch_predictor_tb import bp_pkg::*; ();

	// words per trace line
	localparam int COLS = 13;
	// line limit, also bounds the stimulus loop in cycles
	localparam int MAX_LINES = 200;
	localparam int REPORT_TIMEOUT = 10;

	logic        clock;
	logic        reset;
	logic        predict_valid;
	logic [31:0] predict_pc;
	logic        resolve_valid;
	obq_idx_t    resolve_tag;
	logic        resolve_taken;
	logic        retire_valid;
	obq_idx_t    retire_count;
	logic        pred_taken;
	obq_idx_t    pred_tag;
	logic        mispredict;
	obq_idx_t    obq_count;
	logic        obq_full;

	// expected columns of the line in flight
	logic [7:0]  test_num;
	logic        line_valid;
	logic        trace_done;
	logic        exp_taken;
	obq_idx_t    exp_tag;
	logic        exp_mispredict;
	obq_idx_t    exp_count;
	logic        exp_full;

	// results from the checker
	logic        report_done;
	int          tests_passed;
	int          tests_failed;
	int          check_count;
	int          error_count;

	logic [31:0] trace [MAX_LINES * COLS];

	branch_predictor i_branch_predictor (.*);

	bp_checker i_bp_checker (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// no strobes, no expected line
	task automatic drive_idle();
		predict_valid  = 1'b0;
		predict_pc     = '0;
		resolve_valid  = 1'b0;
		resolve_tag    = '0;
		resolve_taken  = 1'b0;
		retire_valid   = 1'b0;
		retire_count   = '0;
		line_valid     = 1'b0;
		exp_taken      = 1'b0;
		exp_tag        = '0;
		exp_mispredict = 1'b0;
		exp_count      = '0;
		exp_full       = 1'b0;
	endtask

	// column order matches the trace header
	task automatic apply_line(input int line);
		int base;
		base = line * COLS;
		test_num       = trace[base][7:0];
		predict_valid  = trace[base + 1][0];
		predict_pc     = trace[base + 2];
		resolve_valid  = trace[base + 3][0];
		resolve_tag    = obq_idx_t'(trace[base + 4]);
		resolve_taken  = trace[base + 5][0];
		retire_valid   = trace[base + 6][0];
		retire_count   = obq_idx_t'(trace[base + 7]);
		exp_taken      = trace[base + 8][0];
		exp_tag        = obq_idx_t'(trace[base + 9]);
		exp_mispredict = trace[base + 10][0];
		exp_count      = obq_idx_t'(trace[base + 11]);
		exp_full       = trace[base + 12][0];
		line_valid     = 1'b1;
	endtask

	initial begin
		int line;
		int waited;
		bit found_end;
		reset      = 1'b1;
		trace_done = 1'b0;
		test_num   = '0;
		drive_idle();
		$readmemh("tb/bp_trace.txt", trace);
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		// one line per cycle, inputs land 1 unit after the edge
		line      = 0;
		found_end = 1'b0;
		while (!found_end && line < MAX_LINES) begin
			if (trace[line * COLS] === 32'hff) begin
				found_end = 1'b1;
			end else begin
				apply_line(line);
				line++;
				@(posedge clock);
				#1;
			end
		end
		drive_idle();
		trace_done = found_end;
		// checker closes the last test on its next sample
		waited = 0;
		while (found_end && !report_done && waited < REPORT_TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, check_count, error_count);
		if (found_end && report_done && check_count > 0 && error_count == 0) begin
			$display("All checks passed");
		end else begin
			if (!found_end) begin
				$display("trace has no end marker within %0d lines", MAX_LINES);
			end else if (!report_done) begin
				$display("checker gave no report within %0d cycles", REPORT_TIMEOUT);
			end else if (check_count == 0) begin
				$display("trace ran without a single comparison");
			end
			$display("Checks failed");
		end
		$finish;
	end

endmodule
